//--- src/bus_pkg.sv
package bus_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int RESP_W = 2;

    // response codes
    localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
    localparam logic [RESP_W-1:0] RESP_DECERR = 2'b11;

    // address map
    localparam logic [ADDR_W-1:0] RAM_BASE   = 32'h8000_0000;
    localparam int                RAM_WORDS  = 256;
    localparam logic [ADDR_W-1:0] TIMER_BASE = 32'h0200_0000;

    // timer register offsets, block spans 16 bytes
    localparam logic [3:0] TIMER_MTIME_LO = 4'h0;
    localparam logic [3:0] TIMER_MTIME_HI = 4'h4;
    localparam logic [3:0] TIMER_CMP_LO   = 4'h8;
    localparam logic [3:0] TIMER_CMP_HI   = 4'hC;

endpackage

//--- src/arbiter.sv
`timescale 1ns/1ps

module arbiter (
    input  logic                         clk,
    input  logic                         rst_n,
    // fetch master, read only
    input  logic [bus_pkg::ADDR_W-1:0]   m0_araddr,
    input  logic                         m0_arvalid,
    output logic                         m0_arready,
    output logic [bus_pkg::DATA_W-1:0]   m0_rdata,
    output logic [bus_pkg::RESP_W-1:0]   m0_rresp,
    output logic                         m0_rvalid,
    input  logic                         m0_rready,
    // load/store master
    input  logic [bus_pkg::ADDR_W-1:0]   m1_araddr,
    input  logic                         m1_arvalid,
    output logic                         m1_arready,
    output logic [bus_pkg::DATA_W-1:0]   m1_rdata,
    output logic [bus_pkg::RESP_W-1:0]   m1_rresp,
    output logic                         m1_rvalid,
    input  logic                         m1_rready,
    input  logic [bus_pkg::ADDR_W-1:0]   m1_awaddr,
    input  logic                         m1_awvalid,
    output logic                         m1_awready,
    input  logic [bus_pkg::DATA_W-1:0]   m1_wdata,
    input  logic [bus_pkg::STRB_W-1:0]   m1_wstrb,
    input  logic                         m1_wvalid,
    output logic                         m1_wready,
    output logic [bus_pkg::RESP_W-1:0]   m1_bresp,
    output logic                         m1_bvalid,
    input  logic                         m1_bready,
    // merged bus towards the crossbar
    output logic [bus_pkg::ADDR_W-1:0]   arb_araddr,
    output logic                         arb_arvalid,
    input  logic                         arb_arready,
    input  logic [bus_pkg::DATA_W-1:0]   arb_rdata,
    input  logic [bus_pkg::RESP_W-1:0]   arb_rresp,
    input  logic                         arb_rvalid,
    output logic                         arb_rready,
    output logic [bus_pkg::ADDR_W-1:0]   arb_awaddr,
    output logic                         arb_awvalid,
    input  logic                         arb_awready,
    output logic [bus_pkg::DATA_W-1:0]   arb_wdata,
    output logic [bus_pkg::STRB_W-1:0]   arb_wstrb,
    output logic                         arb_wvalid,
    input  logic                         arb_wready,
    input  logic [bus_pkg::RESP_W-1:0]   arb_bresp,
    input  logic                         arb_bvalid,
    output logic                         arb_bready
);

    // 0 = fetch, 1 = load/store
    logic grant;
    logic pick;
    logic outstanding;
    logic issue_ok;
    logic req_start;
    logic req_done;

    // load/store wins, otherwise keep the current owner
    assign pick = (m1_arvalid || m1_awvalid) ? 1'b1 : (m0_arvalid ? 1'b0 : grant);

    // requests only pass once the register already points at the winner
    assign issue_ok  = !outstanding && (grant == pick);
    assign req_start = (arb_arvalid && arb_arready) || (arb_awvalid && arb_awready);
    assign req_done  = (arb_rvalid && arb_rready) || (arb_bvalid && arb_bready);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            grant       <= 1'b0;
            outstanding <= 1'b0;
        end else begin
            if (!outstanding) begin
                grant <= pick;
            end
            if (req_start) begin
                outstanding <= 1'b1;
            end else if (req_done) begin
                outstanding <= 1'b0;
            end
        end
    end

    // bus side
    assign arb_araddr  = grant ? m1_araddr : m0_araddr;
    assign arb_arvalid = issue_ok && (grant ? m1_arvalid : m0_arvalid);
    assign arb_rready  = grant ? m1_rready : m0_rready;
    assign arb_awaddr  = grant ? m1_awaddr : '0;
    assign arb_awvalid = issue_ok && grant && m1_awvalid;
    assign arb_wdata   = grant ? m1_wdata : '0;
    assign arb_wstrb   = grant ? m1_wstrb : '0;
    assign arb_wvalid  = issue_ok && grant && m1_wvalid;
    assign arb_bready  = grant && m1_bready;

    // fetch side, zero unless granted
    assign m0_arready = issue_ok && !grant && arb_arready;
    assign m0_rvalid  = !grant && arb_rvalid;
    assign m0_rdata   = m0_rvalid ? arb_rdata : '0;
    assign m0_rresp   = m0_rvalid ? arb_rresp : '0;

    // load/store side
    assign m1_arready = issue_ok && grant && arb_arready;
    assign m1_rvalid  = grant && arb_rvalid;
    assign m1_rdata   = m1_rvalid ? arb_rdata : '0;
    assign m1_rresp   = m1_rvalid ? arb_rresp : '0;
    assign m1_awready = issue_ok && grant && arb_awready;
    assign m1_wready  = issue_ok && grant && arb_wready;
    assign m1_bvalid  = grant && arb_bvalid;
    assign m1_bresp   = m1_bvalid ? arb_bresp : '0;

    // owner stays put while its response is pending
    a_grant_locked: assert property (@(posedge clk) disable iff (!rst_n)
        (arb_rvalid || arb_bvalid) |-> $stable(grant));

endmodule

//--- src/xbar.sv
`timescale 1ns/1ps

module xbar (
    input  logic                         clk,
    input  logic                         rst_n,
    // from the arbiter
    input  logic [bus_pkg::ADDR_W-1:0]   arb_araddr,
    input  logic                         arb_arvalid,
    output logic                         arb_arready,
    output logic [bus_pkg::DATA_W-1:0]   arb_rdata,
    output logic [bus_pkg::RESP_W-1:0]   arb_rresp,
    output logic                         arb_rvalid,
    input  logic                         arb_rready,
    input  logic [bus_pkg::ADDR_W-1:0]   arb_awaddr,
    input  logic                         arb_awvalid,
    output logic                         arb_awready,
    input  logic [bus_pkg::DATA_W-1:0]   arb_wdata,
    input  logic [bus_pkg::STRB_W-1:0]   arb_wstrb,
    input  logic                         arb_wvalid,
    output logic                         arb_wready,
    output logic [bus_pkg::RESP_W-1:0]   arb_bresp,
    output logic                         arb_bvalid,
    input  logic                         arb_bready,
    // to the RAM
    output logic [bus_pkg::ADDR_W-1:0]   ram_araddr,
    output logic                         ram_arvalid,
    input  logic                         ram_arready,
    input  logic [bus_pkg::DATA_W-1:0]   ram_rdata,
    input  logic [bus_pkg::RESP_W-1:0]   ram_rresp,
    input  logic                         ram_rvalid,
    output logic                         ram_rready,
    output logic [bus_pkg::ADDR_W-1:0]   ram_awaddr,
    output logic                         ram_awvalid,
    input  logic                         ram_awready,
    output logic [bus_pkg::DATA_W-1:0]   ram_wdata,
    output logic [bus_pkg::STRB_W-1:0]   ram_wstrb,
    output logic                         ram_wvalid,
    input  logic                         ram_wready,
    input  logic [bus_pkg::RESP_W-1:0]   ram_bresp,
    input  logic                         ram_bvalid,
    output logic                         ram_bready,
    // to the timer
    output logic [bus_pkg::ADDR_W-1:0]   tmr_araddr,
    output logic                         tmr_arvalid,
    input  logic                         tmr_arready,
    input  logic [bus_pkg::DATA_W-1:0]   tmr_rdata,
    input  logic [bus_pkg::RESP_W-1:0]   tmr_rresp,
    input  logic                         tmr_rvalid,
    output logic                         tmr_rready,
    output logic [bus_pkg::ADDR_W-1:0]   tmr_awaddr,
    output logic                         tmr_awvalid,
    input  logic                         tmr_awready,
    output logic [bus_pkg::DATA_W-1:0]   tmr_wdata,
    output logic [bus_pkg::STRB_W-1:0]   tmr_wstrb,
    output logic                         tmr_wvalid,
    input  logic                         tmr_wready,
    input  logic [bus_pkg::RESP_W-1:0]   tmr_bresp,
    input  logic                         tmr_bvalid,
    output logic                         tmr_bready
);

    logic ar_ram;
    logic ar_tmr;
    logic aw_ram;
    logic aw_tmr;
    logic ar_hs;
    logic aw_hs;
    // target of the outstanding transfer, neither set means decode error
    logic sel_ram;
    logic sel_tmr;
    logic err_rvalid;
    logic err_bvalid;
    logic err_busy;

    function automatic logic in_ram(input logic [bus_pkg::ADDR_W-1:0] addr);
        return addr >= bus_pkg::RAM_BASE &&
               addr < bus_pkg::RAM_BASE + 4 * bus_pkg::RAM_WORDS;
    endfunction

    function automatic logic in_tmr(input logic [bus_pkg::ADDR_W-1:0] addr);
        return addr >= bus_pkg::TIMER_BASE && addr < bus_pkg::TIMER_BASE + 16;
    endfunction

    assign ar_ram   = in_ram(arb_araddr);
    assign ar_tmr   = in_tmr(arb_araddr);
    assign aw_ram   = in_ram(arb_awaddr);
    assign aw_tmr   = in_tmr(arb_awaddr);
    assign ar_hs    = arb_arvalid && arb_arready;
    assign aw_hs    = arb_awvalid && arb_awready;
    assign err_busy = err_rvalid || err_bvalid;

    // forward requests
    assign ram_araddr  = arb_araddr;
    assign tmr_araddr  = arb_araddr;
    assign ram_arvalid = arb_arvalid && ar_ram;
    assign tmr_arvalid = arb_arvalid && ar_tmr;
    assign arb_arready = ar_ram ? ram_arready : (ar_tmr ? tmr_arready : !err_busy);

    // W follows the AW decode since both travel together
    assign ram_awaddr  = arb_awaddr;
    assign tmr_awaddr  = arb_awaddr;
    assign ram_wdata   = arb_wdata;
    assign tmr_wdata   = arb_wdata;
    assign ram_wstrb   = arb_wstrb;
    assign tmr_wstrb   = arb_wstrb;
    assign ram_awvalid = arb_awvalid && aw_ram;
    assign tmr_awvalid = arb_awvalid && aw_tmr;
    assign ram_wvalid  = arb_wvalid && aw_ram;
    assign tmr_wvalid  = arb_wvalid && aw_tmr;
    assign arb_awready = aw_ram ? ram_awready : (aw_tmr ? tmr_awready : !err_busy);
    assign arb_wready  = aw_ram ? ram_wready : (aw_tmr ? tmr_wready : !err_busy);

    // route responses back from the latched target
    assign ram_rready = arb_rready && sel_ram;
    assign tmr_rready = arb_rready && sel_tmr;
    assign ram_bready = arb_bready && sel_ram;
    assign tmr_bready = arb_bready && sel_tmr;
    assign arb_rvalid = sel_ram ? ram_rvalid : (sel_tmr ? tmr_rvalid : err_rvalid);
    assign arb_rdata  = sel_ram ? ram_rdata : (sel_tmr ? tmr_rdata : '0);
    assign arb_rresp  = sel_ram ? ram_rresp : (sel_tmr ? tmr_rresp : bus_pkg::RESP_DECERR);
    assign arb_bvalid = sel_ram ? ram_bvalid : (sel_tmr ? tmr_bvalid : err_bvalid);
    assign arb_bresp  = sel_ram ? ram_bresp : (sel_tmr ? tmr_bresp : bus_pkg::RESP_DECERR);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sel_ram    <= 1'b0;
            sel_tmr    <= 1'b0;
            err_rvalid <= 1'b0;
            err_bvalid <= 1'b0;
        end else begin
            if (ar_hs) begin
                sel_ram <= ar_ram;
                sel_tmr <= ar_tmr;
            end else if (aw_hs) begin
                sel_ram <= aw_ram;
                sel_tmr <= aw_tmr;
            end
            // unmapped: answer ourselves a cycle later
            if (ar_hs && !ar_ram && !ar_tmr) begin
                err_rvalid <= 1'b1;
            end else if (arb_rready) begin
                err_rvalid <= 1'b0;
            end
            if (aw_hs && !aw_ram && !aw_tmr) begin
                err_bvalid <= 1'b1;
            end else if (arb_bready) begin
                err_bvalid <= 1'b0;
            end
        end
    end

    a_one_slave: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({ram_arvalid || ram_awvalid, tmr_arvalid || tmr_awvalid}));

endmodule

//--- src/axi_ram.sv
`timescale 1ns/1ps

module axi_ram (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [bus_pkg::ADDR_W-1:0]   araddr,
    input  logic                         arvalid,
    output logic                         arready,
    output logic [bus_pkg::DATA_W-1:0]   rdata,
    output logic [bus_pkg::RESP_W-1:0]   rresp,
    output logic                         rvalid,
    input  logic                         rready,
    input  logic [bus_pkg::ADDR_W-1:0]   awaddr,
    input  logic                         awvalid,
    output logic                         awready,
    input  logic [bus_pkg::DATA_W-1:0]   wdata,
    input  logic [bus_pkg::STRB_W-1:0]   wstrb,
    input  logic                         wvalid,
    output logic                         wready,
    output logic [bus_pkg::RESP_W-1:0]   bresp,
    output logic                         bvalid,
    input  logic                         bready
);

    logic [bus_pkg::DATA_W-1:0]              mem [bus_pkg::RAM_WORDS];
    logic [$clog2(bus_pkg::RAM_WORDS)-1:0]   rd_idx;
    logic [$clog2(bus_pkg::RAM_WORDS)-1:0]   wr_idx;
    logic                                    ar_hs;
    logic                                    wr_hs;

    // base is aligned, so the word offset is just the low address bits
    assign rd_idx = araddr[$clog2(bus_pkg::RAM_WORDS)+1:2];
    assign wr_idx = awaddr[$clog2(bus_pkg::RAM_WORDS)+1:2];

    // stall new requests while any response waits
    assign arready = !(rvalid || bvalid);
    assign awready = !(rvalid || bvalid);
    assign wready  = !(rvalid || bvalid);
    assign ar_hs   = arvalid && arready;
    assign wr_hs   = awvalid && awready && wvalid && wready;
    assign rresp   = bus_pkg::RESP_OKAY;
    assign bresp   = bus_pkg::RESP_OKAY;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            if (ar_hs) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            if (wr_hs) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rdata <= mem[rd_idx];
        end
        // byte lanes
        if (wr_hs) begin
            for (int i = 0; i < bus_pkg::STRB_W; i++) begin
                if (wstrb[i]) begin
                    mem[wr_idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

//--- src/timer_regs.sv
`timescale 1ns/1ps

module timer_regs (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [bus_pkg::ADDR_W-1:0]   araddr,
    input  logic                         arvalid,
    output logic                         arready,
    output logic [bus_pkg::DATA_W-1:0]   rdata,
    output logic [bus_pkg::RESP_W-1:0]   rresp,
    output logic                         rvalid,
    input  logic                         rready,
    input  logic [bus_pkg::ADDR_W-1:0]   awaddr,
    input  logic                         awvalid,
    output logic                         awready,
    input  logic [bus_pkg::DATA_W-1:0]   wdata,
    input  logic [bus_pkg::STRB_W-1:0]   wstrb,
    input  logic                         wvalid,
    output logic                         wready,
    output logic [bus_pkg::RESP_W-1:0]   bresp,
    output logic                         bvalid,
    input  logic                         bready,
    output logic                         timer_irq
);

    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic        ar_hs;
    logic        wr_hs;

    function automatic logic [bus_pkg::DATA_W-1:0] merge(
        input logic [bus_pkg::DATA_W-1:0] old_word,
        input logic [bus_pkg::DATA_W-1:0] new_word,
        input logic [bus_pkg::STRB_W-1:0] strb
    );
        logic [bus_pkg::DATA_W-1:0] res;
        res = old_word;
        for (int i = 0; i < bus_pkg::STRB_W; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign arready = !(rvalid || bvalid);
    assign awready = !(rvalid || bvalid);
    assign wready  = !(rvalid || bvalid);
    assign ar_hs   = arvalid && arready;
    assign wr_hs   = awvalid && awready && wvalid && wready;
    assign rresp   = bus_pkg::RESP_OKAY;
    assign bresp   = bus_pkg::RESP_OKAY;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtime     <= '0;
            mtimecmp  <= '1;
            rvalid    <= 1'b0;
            bvalid    <= 1'b0;
            timer_irq <= 1'b0;
        end else begin
            mtime     <= mtime + 64'd1;
            timer_irq <= mtime >= mtimecmp;
            // a written word overrides the increment
            if (wr_hs) begin
                case (awaddr[3:0])
                    bus_pkg::TIMER_MTIME_LO: mtime[31:0]     <= merge(mtime[31:0], wdata, wstrb);
                    bus_pkg::TIMER_MTIME_HI: mtime[63:32]    <= merge(mtime[63:32], wdata, wstrb);
                    bus_pkg::TIMER_CMP_LO: mtimecmp[31:0]    <= merge(mtimecmp[31:0], wdata, wstrb);
                    bus_pkg::TIMER_CMP_HI: mtimecmp[63:32]   <= merge(mtimecmp[63:32], wdata, wstrb);
                    default: ;
                endcase
            end
            if (ar_hs) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            if (wr_hs) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            case (araddr[3:0])
                bus_pkg::TIMER_MTIME_LO: rdata <= mtime[31:0];
                bus_pkg::TIMER_MTIME_HI: rdata <= mtime[63:32];
                bus_pkg::TIMER_CMP_LO: rdata <= mtimecmp[31:0];
                bus_pkg::TIMER_CMP_HI: rdata <= mtimecmp[63:32];
                default: rdata <= '0;
            endcase
        end
    end

endmodule

//--- src/bus_top.sv
`timescale 1ns/1ps

module bus_top (
    input  logic                         clk,
    input  logic                         rst_n,
    // fetch
    input  logic [bus_pkg::ADDR_W-1:0]   m0_araddr,
    input  logic                         m0_arvalid,
    output logic                         m0_arready,
    output logic [bus_pkg::DATA_W-1:0]   m0_rdata,
    output logic [bus_pkg::RESP_W-1:0]   m0_rresp,
    output logic                         m0_rvalid,
    input  logic                         m0_rready,
    // load/store
    input  logic [bus_pkg::ADDR_W-1:0]   m1_araddr,
    input  logic                         m1_arvalid,
    output logic                         m1_arready,
    output logic [bus_pkg::DATA_W-1:0]   m1_rdata,
    output logic [bus_pkg::RESP_W-1:0]   m1_rresp,
    output logic                         m1_rvalid,
    input  logic                         m1_rready,
    input  logic [bus_pkg::ADDR_W-1:0]   m1_awaddr,
    input  logic                         m1_awvalid,
    output logic                         m1_awready,
    input  logic [bus_pkg::DATA_W-1:0]   m1_wdata,
    input  logic [bus_pkg::STRB_W-1:0]   m1_wstrb,
    input  logic                         m1_wvalid,
    output logic                         m1_wready,
    output logic [bus_pkg::RESP_W-1:0]   m1_bresp,
    output logic                         m1_bvalid,
    input  logic                         m1_bready,
    output logic                         timer_irq
);

    logic [bus_pkg::ADDR_W-1:0] arb_araddr, arb_awaddr, ram_araddr, ram_awaddr;
    logic [bus_pkg::ADDR_W-1:0] tmr_araddr, tmr_awaddr;
    logic [bus_pkg::DATA_W-1:0] arb_rdata, arb_wdata, ram_rdata, ram_wdata;
    logic [bus_pkg::DATA_W-1:0] tmr_rdata, tmr_wdata;
    logic [bus_pkg::STRB_W-1:0] arb_wstrb, ram_wstrb, tmr_wstrb;
    logic [bus_pkg::RESP_W-1:0] arb_rresp, arb_bresp, ram_rresp, ram_bresp;
    logic [bus_pkg::RESP_W-1:0] tmr_rresp, tmr_bresp;
    logic arb_arvalid, arb_arready, arb_rvalid, arb_rready, arb_awvalid, arb_awready;
    logic arb_wvalid, arb_wready, arb_bvalid, arb_bready;
    logic ram_arvalid, ram_arready, ram_rvalid, ram_rready, ram_awvalid, ram_awready;
    logic ram_wvalid, ram_wready, ram_bvalid, ram_bready;
    logic tmr_arvalid, tmr_arready, tmr_rvalid, tmr_rready, tmr_awvalid, tmr_awready;
    logic tmr_wvalid, tmr_wready, tmr_bvalid, tmr_bready;

    // port names line up with the prefixed wires
    arbiter i_arbiter (.*);

    xbar i_xbar (.*);

    axi_ram i_ram (
        .clk, .rst_n,
        .araddr(ram_araddr), .arvalid(ram_arvalid), .arready(ram_arready),
        .rdata(ram_rdata), .rresp(ram_rresp), .rvalid(ram_rvalid), .rready(ram_rready),
        .awaddr(ram_awaddr), .awvalid(ram_awvalid), .awready(ram_awready),
        .wdata(ram_wdata), .wstrb(ram_wstrb), .wvalid(ram_wvalid), .wready(ram_wready),
        .bresp(ram_bresp), .bvalid(ram_bvalid), .bready(ram_bready)
    );

    timer_regs i_timer (
        .clk, .rst_n,
        .araddr(tmr_araddr), .arvalid(tmr_arvalid), .arready(tmr_arready),
        .rdata(tmr_rdata), .rresp(tmr_rresp), .rvalid(tmr_rvalid), .rready(tmr_rready),
        .awaddr(tmr_awaddr), .awvalid(tmr_awvalid), .awready(tmr_awready),
        .wdata(tmr_wdata), .wstrb(tmr_wstrb), .wvalid(tmr_wvalid), .wready(tmr_wready),
        .bresp(tmr_bresp), .bvalid(tmr_bvalid), .bready(tmr_bready),
        .timer_irq
    );

endmodule

//--- tests/tb_bus_top.sv
`timescale 1ns/1ps

module tb_bus_top;

    localparam int TIMEOUT = 40;
    localparam int NWORDS  = 6;

    logic                         clk;
    logic                         rst_n;
    logic [bus_pkg::ADDR_W-1:0]   m0_araddr;
    logic                         m0_arvalid;
    logic                         m0_arready;
    logic [bus_pkg::DATA_W-1:0]   m0_rdata;
    logic [bus_pkg::RESP_W-1:0]   m0_rresp;
    logic                         m0_rvalid;
    logic                         m0_rready;
    logic [bus_pkg::ADDR_W-1:0]   m1_araddr;
    logic                         m1_arvalid;
    logic                         m1_arready;
    logic [bus_pkg::DATA_W-1:0]   m1_rdata;
    logic [bus_pkg::RESP_W-1:0]   m1_rresp;
    logic                         m1_rvalid;
    logic                         m1_rready;
    logic [bus_pkg::ADDR_W-1:0]   m1_awaddr;
    logic                         m1_awvalid;
    logic                         m1_awready;
    logic [bus_pkg::DATA_W-1:0]   m1_wdata;
    logic [bus_pkg::STRB_W-1:0]   m1_wstrb;
    logic                         m1_wvalid;
    logic                         m1_wready;
    logic [bus_pkg::RESP_W-1:0]   m1_bresp;
    logic                         m1_bvalid;
    logic                         m1_bready;
    logic                         timer_irq;

    // expected RAM contents for the words under test
    logic [31:0] model [NWORDS];
    logic [31:0] word;
    logic [31:0] data;
    logic [31:0] d0;
    logic [31:0] d1;
    logic [31:0] t;
    logic [31:0] v;
    logic [1:0]  resp;
    logic [1:0]  r0;
    logic [1:0]  r1;
    logic [3:0]  strb;
    logic        irq;
    logic        done;
    int          k;
    int          n;
    int          seed;

    bus_top i_dut (.*);

    always #50 clk = ~clk;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            fail_now($sformatf("** Error at %0t ns: %s (got %h, expected %h)",
                               $time, what, got, exp));
        end
    endtask

    function automatic logic [31:0] byte_mask(input logic [3:0] s);
        return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
    endfunction

    // spread the test words over the whole RAM, 51 words apart
    function automatic logic [31:0] ram_addr(input int idx);
        return bus_pkg::RAM_BASE + 32'(204 * idx);
    endfunction

    function automatic logic [31:0] timer_addr(input logic [3:0] off);
        return bus_pkg::TIMER_BASE + 32'(off);
    endfunction

    // fetch is not granted, so its lines must read as zero
    task automatic fetch_side_idle();
        check(32'(m0_arready), 32'd0, "fetch arready while load/store owns the bus");
        check(32'(m0_rvalid), 32'd0, "fetch rvalid while load/store owns the bus");
        check(m0_rdata, 32'd0, "fetch rdata not zero");
        check(32'(m0_rresp), 32'd0, "fetch rresp not zero");
    endtask

    task automatic lsu_write(input logic [31:0] addr, input logic [31:0] wd,
                             input logic [3:0] ws, output logic [1:0] br);
        int cnt;
        m1_awaddr  = addr;
        m1_awvalid = 1'b1;
        m1_wdata   = wd;
        m1_wstrb   = ws;
        m1_wvalid  = 1'b1;
        cnt = 0;
        @(negedge clk);
        while (!(m1_awready && m1_wready)) begin
            cnt++;
            if (cnt > TIMEOUT) fail_now("timeout waiting for awready and wready on load/store");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        m1_awvalid = 1'b0;
        m1_wvalid  = 1'b0;
        m1_bready  = 1'b1;
        cnt = 0;
        @(negedge clk);
        while (!m1_bvalid) begin
            cnt++;
            if (cnt > TIMEOUT) fail_now("timeout waiting for bvalid on load/store");
            @(negedge clk);
        end
        fetch_side_idle();
        br = m1_bresp;
        @(posedge clk);
        #1;
        m1_bready = 1'b0;
    endtask

    // hold keeps rready low for that many cycles after rvalid shows up
    task automatic lsu_read(input logic [31:0] addr, input int hold,
                            output logic [31:0] rd, output logic [1:0] rr);
        int cnt;
        m1_araddr  = addr;
        m1_arvalid = 1'b1;
        cnt = 0;
        @(negedge clk);
        while (!m1_arready) begin
            cnt++;
            if (cnt > TIMEOUT) fail_now("timeout waiting for arready on load/store");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        m1_arvalid = 1'b0;
        m1_rready  = (hold == 0);
        cnt = 0;
        @(negedge clk);
        while (!m1_rvalid) begin
            cnt++;
            if (cnt > TIMEOUT) fail_now("timeout waiting for rvalid on load/store");
            @(negedge clk);
        end
        fetch_side_idle();
        rd = m1_rdata;
        rr = m1_rresp;
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check(32'(m1_rvalid), 32'd1, "rvalid dropped under back-pressure");
            check(m1_rdata, rd, "rdata changed under back-pressure");
            fetch_side_idle();
        end
        if (hold > 0) begin
            @(posedge clk);
            #1;
            m1_rready = 1'b1;
        end
        @(posedge clk);
        #1;
        m1_rready = 1'b0;
    endtask

    // finishes a fetch read whose AR is already driven
    task automatic fetch_complete(output logic [31:0] rd, output logic [1:0] rr);
        int cnt;
        m0_rready = 1'b1;
        cnt = 0;
        @(negedge clk);
        while (!m0_arready) begin
            cnt++;
            if (cnt > TIMEOUT) fail_now("timeout waiting for arready on fetch");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        m0_arvalid = 1'b0;
        cnt = 0;
        @(negedge clk);
        while (!m0_rvalid) begin
            cnt++;
            if (cnt > TIMEOUT) fail_now("timeout waiting for rvalid on fetch");
            @(negedge clk);
        end
        rd = m0_rdata;
        rr = m0_rresp;
        @(posedge clk);
        #1;
        m0_rready = 1'b0;
    endtask

    task automatic fetch_read(input logic [31:0] addr, output logic [31:0] rd,
                              output logic [1:0] rr);
        m0_araddr  = addr;
        m0_arvalid = 1'b1;
        fetch_complete(rd, rr);
    endtask

    initial begin
        seed       = 76318;
        clk        = 1'b0;
        rst_n      = 1'b0;
        m0_araddr  = '0;
        m0_arvalid = 1'b0;
        m0_rready  = 1'b0;
        m1_araddr  = '0;
        m1_arvalid = 1'b0;
        m1_rready  = 1'b0;
        m1_awaddr  = '0;
        m1_awvalid = 1'b0;
        m1_wdata   = '0;
        m1_wstrb   = '0;
        m1_wvalid  = 1'b0;
        m1_bready  = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // load/store writes, full words then partial strobes
        for (k = 0; k < NWORDS; k++) begin
            word = $random(seed);
            lsu_write(ram_addr(k), word, 4'hF, resp);
            check(32'(resp), 32'(bus_pkg::RESP_OKAY), "full write response");
            model[k] = word;
        end
        for (k = 0; k < NWORDS; k++) begin
            word = $random(seed);
            strb = 4'(2 * k + 1);
            lsu_write(ram_addr(k), word, strb, resp);
            check(32'(resp), 32'(bus_pkg::RESP_OKAY), "partial write response");
            model[k] = (model[k] & ~byte_mask(strb)) | (word & byte_mask(strb));
        end
        for (k = 0; k < NWORDS; k++) begin
            lsu_read(ram_addr(k), 0, data, resp);
            check(data, model[k], "load/store read-back data");
            check(32'(resp), 32'(bus_pkg::RESP_OKAY), "load/store read response");
        end

        // fetch reads of the same words
        check(32'(m0_rvalid), 32'd0, "fetch rvalid with no request");
        check(m0_rdata, 32'd0, "fetch rdata with no request");
        check(32'(m0_rresp), 32'd0, "fetch rresp with no request");
        for (k = 0; k < NWORDS; k++) begin
            fetch_read(ram_addr(k), data, resp);
            check(data, model[k], "fetch read data");
            check(32'(resp), 32'(bus_pkg::RESP_OKAY), "fetch read response");
        end

        // same-cycle requests, load/store goes first
        m0_araddr  = ram_addr(1);
        m0_arvalid = 1'b1;
        lsu_read(ram_addr(3), 0, d1, r1);
        fetch_complete(d0, r0);
        check(d1, model[3], "load/store data after priority win");
        check(32'(r1), 32'(bus_pkg::RESP_OKAY), "load/store response after priority win");
        check(d0, model[1], "fetch data after losing priority");
        check(32'(r0), 32'(bus_pkg::RESP_OKAY), "fetch response after losing priority");

        // fetch arrives while a load/store read is back-pressured
        fork
            lsu_read(ram_addr(3), 6, d1, r1);
            begin
                repeat (3) @(posedge clk);
                #1;
                m0_araddr  = ram_addr(1);
                m0_arvalid = 1'b1;
            end
        join
        fetch_complete(d0, r0);
        check(d1, model[3], "load/store data under grant lock");
        check(32'(r1), 32'(bus_pkg::RESP_OKAY), "load/store response under grant lock");
        check(d0, model[1], "fetch data after grant lock");
        check(32'(r0), 32'(bus_pkg::RESP_OKAY), "fetch response after grant lock");

        // unmapped address, write aliases word 1 in the low bits
        lsu_read(32'h4000_0000, 0, data, resp);
        check(32'(resp), 32'(bus_pkg::RESP_DECERR), "unmapped read response");
        check(data, 32'd0, "unmapped read data");
        lsu_write(32'h4000_0000 + 32'd204, 32'hDEAD_BEEF, 4'hF, resp);
        check(32'(resp), 32'(bus_pkg::RESP_DECERR), "unmapped write response");
        lsu_read(ram_addr(1), 0, data, resp);
        check(data, model[1], "RAM word changed by unmapped write");

        // timer
        lsu_read(timer_addr(bus_pkg::TIMER_MTIME_LO), 0, t, resp);
        check(32'(resp), 32'(bus_pkg::RESP_OKAY), "mtime read response");
        lsu_read(timer_addr(bus_pkg::TIMER_MTIME_LO), 0, v, resp);
        check(32'(v > t), 32'd1, "mtime did not increase");
        t = v;
        lsu_write(timer_addr(bus_pkg::TIMER_CMP_LO), t + 32'd20, 4'hF, resp);
        lsu_write(timer_addr(bus_pkg::TIMER_CMP_HI), 32'd0, 4'hF, resp);
        check(32'(timer_irq), 32'd0, "timer_irq high right after mtimecmp write");
        // poll, each read gives an upper bound on mtime when irq was sampled
        done = 1'b0;
        n = 0;
        while (!done) begin
            irq = timer_irq;
            lsu_read(timer_addr(bus_pkg::TIMER_MTIME_LO), 0, v, resp);
            if (irq) begin
                check(32'(v >= t + 32'd10), 32'd1, "timer_irq rose too early");
                done = 1'b1;
            end
            n++;
            if (!done && n > TIMEOUT) fail_now("timeout waiting for timer_irq to rise");
        end
        lsu_write(timer_addr(bus_pkg::TIMER_CMP_LO), 32'hFFFF_FFFF, 4'hF, resp);
        lsu_write(timer_addr(bus_pkg::TIMER_CMP_HI), 32'hFFFF_FFFF, 4'hF, resp);
        n = 0;
        while (timer_irq) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) fail_now("timeout waiting for timer_irq to clear");
        end

        // back-pressure on a plain read
        lsu_read(ram_addr(4), 5, data, resp);
        check(data, model[4], "read data under back-pressure");
        check(32'(resp), 32'(bus_pkg::RESP_OKAY), "read response under back-pressure");

        $display("test passed");
        $finish;
    end

endmodule

//--- vlog.f
src/bus_pkg.sv
src/arbiter.sv
src/xbar.sv
src/axi_ram.sv
src/timer_regs.sv
src/bus_top.sv
tests/tb_bus_top.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the bus testbench with Verilator, nonzero exit on failure
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert -f vlog.f --top-module tb_bus_top \
        -o sim_tb_bus_top &&
    ./obj_dir/sim_tb_bus_top || exit 1
